/* include/icache_defs.svh */
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// cache geometry, 4 ways x 16 sets x 16 byte lines

`define ICACHE_WAY_BIT      2   // way number width
`define ICACHE_INDEX_BIT    4   // set index width, addr[7:4]
`define ICACHE_OFFSET_BIT   4   // byte offset inside a line
`define ICACHE_WORDS        4   // 32-bit words per line

// derived values
`define ICACHE_WAYS         (1 << `ICACHE_WAY_BIT)        // ways per set
`define ICACHE_SETS         (1 << `ICACHE_INDEX_BIT)      // number of sets
`define ICACHE_WORD_BIT     (`ICACHE_OFFSET_BIT - 2)      // word select inside a line
`define ICACHE_TAG_BIT      (32 - `ICACHE_INDEX_BIT - `ICACHE_OFFSET_BIT)  // 24 tag bits
`define ICACHE_PLRU_BIT     (`ICACHE_WAYS - 1)            // tree bits per set

// address slicing
`define ICACHE_INDEX_LSB    `ICACHE_OFFSET_BIT
`define ICACHE_INDEX_MSB    (`ICACHE_OFFSET_BIT + `ICACHE_INDEX_BIT - 1)
`define ICACHE_TAG_LSB      (`ICACHE_OFFSET_BIT + `ICACHE_INDEX_BIT)

`endif

/* source/icache_pkg.sv */
`include "icache_defs.svh"

package icache_pkg;

    typedef logic [31:0] addr_t;                          // byte address
    typedef logic [31:0] word_t;                          // one instruction word
    typedef logic [`ICACHE_INDEX_BIT-1:0] index_t;        // set index
    typedef logic [`ICACHE_TAG_BIT-1:0] tag_t;            // upper address bits
    typedef logic [`ICACHE_WAY_BIT-1:0] position_t;       // way number
    typedef logic [`ICACHE_PLRU_BIT-1:0] plru_line_t;     // tree bits of one set

    // what the replacement block is asked to do
    typedef enum logic {
        plru_touch,                                       // mark way as most recent
        plru_victim                                       // report oldest way
    } plru_func_t;

    // controller sequence
    typedef enum logic [2:0] {
        st_idle, st_lookup, st_miss,
        st_fill, st_resp
    } ctrl_state_t;

    // fetch request, valid is a one cycle strobe
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } fetch_req_t;

    // fetch response, one cycle pulse
    typedef struct packed {
        logic  valid;
        logic  hit;                                       // 0 when served by refill
        word_t data;
    } fetch_resp_t;

endpackage

/* source/icache_plru.sv */
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_plru (
    input  logic                   clk,
    input  logic                   resetn,    // active high
    input  logic                   flush,
    input  logic                   en,        // single cycle strobe
    input  icache_pkg::plru_func_t func,
    input  icache_pkg::index_t     index,
    input  icache_pkg::position_t  hit_pos,
    output icache_pkg::position_t  lru_pos
);

    icache_pkg::plru_line_t board [`ICACHE_SETS];   // tree bits per set

    // point every bit on the path of way away from it
    function automatic icache_pkg::plru_line_t touch_path(
        input icache_pkg::plru_line_t line,
        input icache_pkg::position_t  way
    );
        icache_pkg::plru_line_t next;
        next = line;
        next[0] = ~way[1];                           // other pair becomes older
        if (way[1]) begin
            next[2] = ~way[0];                       // ways 2-3 subtree
        end else begin
            next[1] = ~way[0];                       // ways 0-1 subtree
        end
        return next;
    endfunction

    // walk from the root toward the older side
    function automatic icache_pkg::position_t victim_of(
        input icache_pkg::plru_line_t line
    );
        icache_pkg::position_t way;
        if (line[0]) begin
            way = {1'b1, line[2]};                   // pick inside ways 2-3
        end else begin
            way = {1'b0, line[1]};                   // pick inside ways 0-1
        end
        return way;
    endfunction

    logic do_touch;

    assign do_touch = en && (func == icache_pkg::plru_touch);   // victim reads only

    always_ff @(posedge clk) begin
        if (resetn || flush) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                board[s] <= '0;                      // first victim is way 0
            end
        end else if (do_touch) begin
            board[index] <= touch_path(board[index], hit_pos);
        end
    end

    // victim of the addressed set, always valid
    assign lru_pos = victim_of(board[index]);

endmodule

/* source/icache_way_store.sv */
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_way_store (
    input  logic                         clk,
    input  logic                         resetn,         // active high
    input  logic                         flush,          // drop every line
    input  icache_pkg::index_t           lookup_index,
    input  icache_pkg::tag_t             lookup_tag,
    input  logic [`ICACHE_WORD_BIT-1:0]  lookup_word,    // word inside the line
    input  logic                         fill,
    input  icache_pkg::position_t        fill_way,
    input  icache_pkg::word_t [`ICACHE_WORDS-1:0] fill_line,
    output logic                         hit,
    output icache_pkg::position_t        hit_way,
    output icache_pkg::word_t            hit_data
);

    logic [`ICACHE_SETS-1:0] valid [`ICACHE_WAYS];                  // one bit per line
    icache_pkg::tag_t tag_mem [`ICACHE_WAYS][`ICACHE_SETS];         // no reset
    icache_pkg::word_t [`ICACHE_WORDS-1:0] data_mem [`ICACHE_WAYS][`ICACHE_SETS];

    logic [`ICACHE_WAYS-1:0] way_match;                             // per way compare

    // valid bits, cleared on reset or flush
    always_ff @(posedge clk) begin
        if (resetn || flush) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                valid[w] <= '0;
            end
        end else if (fill) begin
            valid[fill_way][lookup_index] <= 1'b1;                 // line now usable
        end
    end

    // tag and data written together on refill
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_mem[fill_way][lookup_index]  <= lookup_tag;
            data_mem[fill_way][lookup_index] <= fill_line;
        end
    end

    // all four tags compared at once
    always_comb begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            way_match[w] = valid[w][lookup_index] &&
                           (tag_mem[w][lookup_index] == lookup_tag);
        end
    end

    // at most one way matches, so a plain encode is enough
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (way_match[w]) begin
                hit_way = icache_pkg::position_t'(w);
            end
        end
    end

    assign hit      = |way_match;
    assign hit_data = data_mem[hit_way][lookup_index][lookup_word];  // word of hit line

endmodule

/* source/icache_ctrl.sv */
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_ctrl (
    input  logic                         clk,
    input  logic                         resetn,        // active high
    input  icache_pkg::fetch_req_t       req,
    input  logic                         flush_req,
    output icache_pkg::fetch_resp_t      resp,
    output logic                         busy,
    // memory side
    output logic                         mem_req,
    output icache_pkg::addr_t            mem_addr,      // line aligned
    output logic [`ICACHE_WORD_BIT-1:0]  mem_word,      // next word expected
    input  logic                         mem_valid,
    input  icache_pkg::word_t            mem_rdata,
    // way store
    output icache_pkg::index_t           lookup_index,
    output icache_pkg::tag_t             lookup_tag,
    output logic [`ICACHE_WORD_BIT-1:0]  lookup_word,
    output logic                         fill,
    output icache_pkg::position_t        fill_way,
    output icache_pkg::word_t [`ICACHE_WORDS-1:0] fill_line,
    output logic                         flush,
    input  logic                         hit,
    input  icache_pkg::position_t        hit_way,
    input  icache_pkg::word_t            hit_data,
    // pseudo-LRU
    output logic                         plru_en,
    output icache_pkg::plru_func_t       plru_func,
    output icache_pkg::position_t        plru_hit_pos,
    input  icache_pkg::position_t        lru_pos
);

    icache_pkg::ctrl_state_t state;
    logic                         mem_req_q;        // one cycle after a miss
    logic                         flush_q;          // flush in progress
    logic [`ICACHE_WORD_BIT-1:0]  word_cnt;         // refill words received
    icache_pkg::addr_t            addr_q;           // request being served
    icache_pkg::position_t        victim_way;       // way chosen for refill
    icache_pkg::word_t [`ICACHE_WORDS-1:0] line_buf;
    logic                         resp_hit_q;
    icache_pkg::word_t            resp_data_q;

    logic accept;
    logic last_word;

    assign accept    = (state == icache_pkg::st_idle) && !flush_q && !flush_req && req.valid;
    assign last_word = mem_valid && (word_cnt == `ICACHE_WORD_BIT'(`ICACHE_WORDS - 1));

    // control state
    always_ff @(posedge clk) begin
        if (resetn) begin
            state     <= icache_pkg::st_idle;
            mem_req_q <= 1'b0;
            flush_q   <= 1'b0;
            word_cnt  <= '0;
        end else begin
            mem_req_q <= 1'b0;                      // both are pulses
            flush_q   <= 1'b0;
            case (state)
                icache_pkg::st_idle: begin
                    if (flush_req && !flush_q) begin
                        flush_q <= 1'b1;            // only taken while idle
                    end else if (accept) begin
                        state <= icache_pkg::st_lookup;
                    end
                end
                icache_pkg::st_lookup: begin
                    if (hit) begin
                        state <= icache_pkg::st_resp;
                    end else begin
                        state     <= icache_pkg::st_miss;
                        mem_req_q <= 1'b1;          // ask for the line
                        word_cnt  <= '0;
                    end
                end
                icache_pkg::st_miss: begin
                    if (mem_valid) begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                    if (last_word) begin
                        state <= icache_pkg::st_fill;
                    end
                end
                icache_pkg::st_fill: state <= icache_pkg::st_resp;
                icache_pkg::st_resp: state <= icache_pkg::st_idle;
                default:             state <= icache_pkg::st_idle;
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= req.addr;                     // index, tag, offset held here
        end
        if (mem_req_q) begin
            victim_way <= lru_pos;                  // victim before the touch
        end
        if ((state == icache_pkg::st_miss) && mem_valid) begin
            line_buf[word_cnt] <= mem_rdata;        // words come in counter order
        end
        if ((state == icache_pkg::st_lookup) && hit) begin
            resp_hit_q  <= 1'b1;
            resp_data_q <= hit_data;
        end else if (state == icache_pkg::st_fill) begin
            resp_hit_q  <= 1'b0;
            resp_data_q <= line_buf[lookup_word];   // served from the buffer
        end
    end

    // address split for the arrays
    assign lookup_index = addr_q[`ICACHE_INDEX_MSB:`ICACHE_INDEX_LSB];
    assign lookup_tag   = addr_q[31:`ICACHE_TAG_LSB];
    assign lookup_word  = addr_q[`ICACHE_OFFSET_BIT-1:2];

    assign mem_req  = mem_req_q;
    assign mem_addr = {addr_q[31:`ICACHE_OFFSET_BIT], {`ICACHE_OFFSET_BIT{1'b0}}};
    assign mem_word = word_cnt;

    assign fill      = (state == icache_pkg::st_fill);
    assign fill_way  = victim_way;
    assign fill_line = line_buf;
    assign flush     = flush_q;

    // touch on hit or fill and plain victim read on the miss request
    assign plru_en      = ((state == icache_pkg::st_lookup) && hit) || mem_req_q || fill;
    assign plru_func    = mem_req_q ? icache_pkg::plru_victim : icache_pkg::plru_touch;
    assign plru_hit_pos = fill ? victim_way : hit_way;

    always_comb begin
        resp.valid = (state == icache_pkg::st_resp);
        resp.hit   = resp_hit_q;
        resp.data  = resp_data_q;
    end

    assign busy = (state != icache_pkg::st_idle) || flush_q;   // low again after resp

endmodule

/* source/icache_top.sv */
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_top (
    input  logic                         clk,
    input  logic                         resetn,      // active high
    input  icache_pkg::fetch_req_t       req,
    input  logic                         flush,       // honoured while idle
    output icache_pkg::fetch_resp_t      resp,
    output logic                         busy,
    output logic                         mem_req,
    output icache_pkg::addr_t            mem_addr,
    output logic [`ICACHE_WORD_BIT-1:0]  mem_word,
    input  logic                         mem_valid,
    input  icache_pkg::word_t            mem_rdata
);

    icache_pkg::index_t           lookup_index;       // shared by store and plru
    icache_pkg::tag_t             lookup_tag;
    logic [`ICACHE_WORD_BIT-1:0]  lookup_word;
    logic                         fill;
    icache_pkg::position_t        fill_way;
    icache_pkg::word_t [`ICACHE_WORDS-1:0] fill_line;
    logic                         cache_flush;        // one cycle clear
    logic                         hit;
    icache_pkg::position_t        hit_way;
    icache_pkg::word_t            hit_data;
    logic                         plru_en;
    icache_pkg::plru_func_t       plru_func;
    icache_pkg::position_t        plru_hit_pos;
    icache_pkg::position_t        lru_pos;

    icache_ctrl icache_ctrl_i (
        .clk, .resetn, .req,
        .flush_req (flush),
        .resp, .busy,
        .mem_req, .mem_addr, .mem_word, .mem_valid, .mem_rdata,
        .lookup_index, .lookup_tag, .lookup_word,
        .fill, .fill_way, .fill_line,
        .flush     (cache_flush),
        .hit, .hit_way, .hit_data,
        .plru_en, .plru_func, .plru_hit_pos, .lru_pos
    );

    icache_way_store icache_way_store_i (
        .clk, .resetn,
        .flush     (cache_flush),
        .lookup_index, .lookup_tag, .lookup_word,
        .fill, .fill_way, .fill_line,
        .hit, .hit_way, .hit_data
    );

    icache_plru icache_plru_i (
        .clk, .resetn,
        .flush     (cache_flush),
        .en        (plru_en),
        .func      (plru_func),
        .index     (lookup_index),
        .hit_pos   (plru_hit_pos),
        .lru_pos
    );

endmodule

/* verification/icache_tb.sv */
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_tb;

    logic                         clk;
    logic                         resetn;         // active high
    icache_pkg::fetch_req_t       req;
    logic                         flush;
    icache_pkg::fetch_resp_t      resp;
    logic                         busy;
    logic                         mem_req;
    icache_pkg::addr_t            mem_addr;
    logic [`ICACHE_WORD_BIT-1:0]  mem_word;
    logic                         mem_valid;
    icache_pkg::word_t            mem_rdata;

    logic [7:0]  op_q [$];                        // opcode per data file line
    logic [31:0] addr_q [$];
    logic        hit_q [$];
    logic [31:0] data_q [$];

    int          errors = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;                 // set once the file is read
    logic        expect_hit = 1'b0;               // current fetch should hit
    logic [31:0] cur_addr = '0;
    logic [31:0] rng_state = 32'h7547_d70f;

    icache_top icache_top_i (
        .clk, .resetn, .req, .flush, .resp, .busy,
        .mem_req, .mem_addr, .mem_word, .mem_valid, .mem_rdata
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                    // 8 ns period
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("Mismatch %s got %h expected %h", name, got, expected);
        end
    endtask

    task automatic load_tests();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [31:0] addr;
        logic [31:0] hit_flag;
        logic [31:0] data;
        fd = $fopen("verification/icache_testdata.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open verification/icache_testdata.txt");
            return;
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 2 || line[0] == "#") continue;   // blank or column notes
            n = $sscanf(line, "%c %h %h %h", op, addr, hit_flag, data);
            if (n != 4) begin
                errors++;
                $display("malformed test data line %s", line);
            end else begin
                op_q.push_back(op);
                addr_q.push_back(addr);
                hit_q.push_back(hit_flag[0]);
                data_q.push_back(data);
            end
        end
        $fclose(fd);
    endtask

    task automatic fetch_and_check(input logic [31:0] addr, input logic exp_hit,
                                   input logic [31:0] exp_data);
        int waited;
        check_value("busy", 32'(busy), 32'd0);     // must be idle to accept
        expect_hit = exp_hit;
        cur_addr   = addr;
        req.valid  = 1'b1;
        req.addr   = addr;
        @(negedge clk);                           // accepting edge passed
        req.valid = 1'b0;
        waited    = 1;
        while (!resp.valid && waited <= 40) begin
            check_value("busy", 32'(busy), 32'd1);
            @(negedge clk);
            waited++;
        end
        if (!resp.valid) begin
            errors++;
            $display("no response within 40 cycles for fetch of %h", addr);
        end else begin
            check_value("busy", 32'(busy), 32'd1);  // still high on the response
            check_value("resp.hit", 32'(resp.hit), 32'(exp_hit));
            check_value("resp.data", resp.data, exp_data);
            if (exp_hit) begin
                check_value("hit latency", waited, 32'd2);   // lookup then response
            end
        end
        @(negedge clk);
    endtask

    task automatic flush_cache();
        check_value("busy", 32'(busy), 32'd0);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        check_value("busy", 32'(busy), 32'd1);     // one cycle clear
        @(negedge clk);
    endtask

    // refill model, words in counter order with random gaps
    initial begin : memory_model
        logic [31:0] line_addr;
        mem_valid = 1'b0;
        mem_rdata = '0;
        forever begin
            @(negedge clk);
            if (mem_req) begin
                if (expect_hit) begin
                    errors++;
                    $display("memory request for line %h on a fetch expected to hit", mem_addr);
                end
                check_value("mem_addr", mem_addr, cur_addr & 32'hffff_fff0);
                line_addr = mem_addr;
                for (int w = 0; w < `ICACHE_WORDS; w++) begin
                    rng_state = xorshift32(rng_state);
                    repeat (rng_state[1:0]) @(negedge clk);   // 0 to 3 idle cycles
                    check_value("mem_word", 32'(mem_word), 32'(w));
                    mem_valid = 1'b1;
                    mem_rdata = (line_addr + 32'(w * 4)) ^ 32'hc0de_0000;
                    @(negedge clk);
                    mem_valid = 1'b0;
                end
            end
        end
    end

    initial begin : watchdog
        wait (cycle_limit != 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, errors so far %0d", cycle_limit, errors);
        $display("test failed");
        $finish;
    end

    initial begin : main
        resetn = 1'b1;
        req    = '0;
        flush  = 1'b0;
        load_tests();
        if (op_q.size() == 0) begin
            errors++;
            $display("no operations read from the test data file");
        end
        cycle_limit = op_q.size() * 40 + 100;    // worst case per operation
        repeat (2) @(negedge clk);                // two reset cycles
        resetn = 1'b0;
        check_value("resp.valid", 32'(resp.valid), 32'd0);
        check_value("mem_req", 32'(mem_req), 32'd0);
        check_value("busy", 32'(busy), 32'd0);
        for (int i = 0; i < op_q.size(); i++) begin
            if (op_q[i] == "X") begin
                flush_cache();
            end else if (op_q[i] == "F") begin
                fetch_and_check(addr_q[i], hit_q[i], data_q[i]);
            end else begin
                errors++;
                $display("unknown opcode %c in the test data file", op_q[i]);
            end
        end
        $display("operations %0d, errors %0d", op_q.size(), errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* verification/icache_testdata.txt */
# columns are opcode (F fetch, X flush), byte address, expected hit, expected data
# refill data is the word address xor c0de0000
F 00000104 0 c0de0104
F 00000100 1 c0de0100
F 00000108 1 c0de0108
F 0000010c 1 c0de010c
F 00001050 0 c0de1050
F 00002054 0 c0de2054
F 00003058 0 c0de3058
F 0000405c 0 c0de405c
F 00001050 1 c0de1050
F 00005050 0 c0de5050
F 00001054 1 c0de1054
F 00003050 1 c0de3050
F 00004050 1 c0de4050
F 00005058 1 c0de5058
F 00002050 0 c0de2050
F 0000105c 0 c0de105c
F 0000305c 1 c0de305c
X 00000000 0 00000000
F 0000010c 0 c0de010c
F 00000100 1 c0de0100
F 00001050 0 c0de1050
F 00002050 0 c0de2050
F 00003050 0 c0de3050
F 00004050 0 c0de4050
F 00005050 0 c0de5050
F 00001054 0 c0de1054

/* icache_top.f */
+incdir+include
source/icache_pkg.sv
source/icache_plru.sv
source/icache_way_store.sv
source/icache_ctrl.sv
source/icache_top.sv
verification/icache_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the icache testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -j 0 -f icache_top.f --top-module icache_tb -Mdir "$OBJ"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$OBJ/Vicache_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi

echo "simulation finished without failures"
exit 0
